//--- list.f
source/dma_pkg.sv
source/dma_nd_req_if.sv
source/dma_burst_if.sv
source/dma_insn_decoder.sv
source/dma_nd_midend.sv
source/dma_backend.sv
source/dma_transfer_id.sv
source/dma_ctrl.sv
tb/dma_ctrl_assert.sv
tb/dma_ctrl_tb.sv

//--- tb/dma_ctrl_tb.sv
// DMA controller testbench
`default_nettype none

module dma_ctrl_tb
  import dma_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_XFERS  = 6;
  localparam int MEM_WORDS  = 256;

  logic  clk;
  logic  rst_n;
  logic  issue_valid;
  word_t issue_instr;
  word_t issue_rs1;
  word_t issue_rs2;
  logic  issue_ready;
  logic  issue_accept;
  logic  ext_req;
  logic  ext_we;
  addr_t ext_addr;
  word_t ext_wdata;
  logic  ext_gnt;
  logic  ext_rvalid;
  word_t ext_rdata;
  logic  loc_req;
  logic  loc_we;
  addr_t loc_addr;
  word_t loc_wdata;
  logic  loc_gnt;
  logic  loc_rvalid;
  word_t loc_rdata;
  logic  start;
  logic  busy;
  logic  done;
  logic  dma_error;

  // Memories seen by the DUT and their model copies
  word_t ext_mem [addr_t];
  word_t loc_mem [addr_t];
  word_t ext_ref [addr_t];
  word_t loc_ref [addr_t];

  // Transfer shapes drawn before the run
  addr_t t_src  [NUM_XFERS];
  addr_t t_dst  [NUM_XFERS];
  addr_t t_sstr [NUM_XFERS];
  addr_t t_dstr [NUM_XFERS];
  len_t  t_len  [NUM_XFERS];
  len_t  t_reps [NUM_XFERS];
  logic  t_dir  [NUM_XFERS];

  integer seed = 32'hc5e9;
  word_t  gnt_mask;
  int     errors;
  int     failed_tests;
  int     total_words;
  int     timeout_cycles;
  int     start_cnt;
  int     done_cnt;
  int     err_cnt;
  int     start_base;
  int     done_base;
  int     err_base;
  int     errs_before;
  logic   req_seen;
  logic   busy_seen;
  logic   busy_gap;
  logic   watch_busy;
  logic   acc;

  dma_ctrl #(
    .BURST_CREDITS ( BURST_CREDITS )
  ) u_dut (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .issue_valid_i  ( issue_valid  ),
    .issue_instr_i  ( issue_instr  ),
    .issue_rs1_i    ( issue_rs1    ),
    .issue_rs2_i    ( issue_rs2    ),
    .issue_ready_o  ( issue_ready  ),
    .issue_accept_o ( issue_accept ),
    .ext_req_o      ( ext_req      ),
    .ext_we_o       ( ext_we       ),
    .ext_addr_o     ( ext_addr     ),
    .ext_wdata_o    ( ext_wdata    ),
    .ext_gnt_i      ( ext_gnt      ),
    .ext_rvalid_i   ( ext_rvalid   ),
    .ext_rdata_i    ( ext_rdata    ),
    .loc_req_o      ( loc_req      ),
    .loc_we_o       ( loc_we       ),
    .loc_addr_o     ( loc_addr     ),
    .loc_wdata_o    ( loc_wdata    ),
    .loc_gnt_i      ( loc_gnt      ),
    .loc_rvalid_i   ( loc_rvalid   ),
    .loc_rdata_i    ( loc_rdata    ),
    .start_o        ( start        ),
    .busy_o         ( busy         ),
    .done_o         ( done         ),
    .error_o        ( dma_error    )
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Odd multiplier keeps every address bit in the fill pattern
  function automatic word_t fill_word(input addr_t a);
    return (a * 32'h9e37_79b9) ^ 32'h3c6e_f372;
  endfunction

  function automatic int unsigned pick(input int unsigned lo, input int unsigned hi);
    return lo + ($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // RISC-V R-type layout with funct3 at bits 14:12
  function automatic word_t make_insn(input logic [6:0] opcode, input logic [2:0] funct3);
    word_t w;
    w        = '0;
    w[6:0]   = opcode;
    w[14:12] = funct3;
    return w;
  endfunction

  // Both memory ports act on pre-edge handshake values
  always @(posedge clk) begin
    ext_rvalid <= 1'b0;
    loc_rvalid <= 1'b0;
    if (ext_req && ext_gnt) begin
      if (ext_we) begin
        ext_mem[ext_addr] = ext_wdata;
      end else begin
        ext_rdata  <= ext_mem.exists(ext_addr) ? ext_mem[ext_addr] : fill_word(ext_addr);
        ext_rvalid <= 1'b1;
      end
    end
    if (loc_req && loc_gnt) begin
      if (loc_we) begin
        loc_mem[loc_addr] = loc_wdata;
      end else begin
        loc_rdata  <= loc_mem.exists(loc_addr) ? loc_mem[loc_addr] : fill_word(loc_addr);
        loc_rvalid <= 1'b1;
      end
    end
    // Random grant delays
    ext_gnt <= (($random(seed) & gnt_mask) == 0);
    loc_gnt <= (($random(seed) & gnt_mask) == 0);
  end

  // Pulse counters and status watch
  always @(posedge clk) begin
    if (rst_n) begin
      // Busy must hold from the first start to the third done
      if (watch_busy && start_cnt > start_base && done_cnt < done_base + 3 && !busy) begin
        busy_gap = 1'b1;
      end
      if (start) start_cnt++;
      if (done) done_cnt++;
      if (dma_error) err_cnt++;
      if (ext_req || loc_req) req_seen = 1'b1;
      if (busy) busy_seen = 1'b1;
    end
  end

  task automatic note_error(input string msg);
    errors++;
    $display("error at %0d ns: %s", $time, msg);
  endtask

  // Runs from just after a rising edge to just after the handshake edge
  task automatic issue_insn(input word_t instr, input word_t rs1, input word_t rs2,
                            output logic accepted);
    issue_valid <= 1'b1;
    issue_instr <= instr;
    issue_rs1   <= rs1;
    issue_rs2   <= rs2;
    do begin
      @(posedge clk);
    end while (!issue_ready);
    accepted = issue_accept;
    issue_valid <= 1'b0;
  endtask

  task automatic configure(input int k);
    logic a;
    issue_insn(make_insn(DMA_OPCODE, FN_SET_ADDR), t_src[k], t_dst[k], a);
    if (!a) note_error("address instruction not accepted");
    issue_insn(make_insn(DMA_OPCODE, FN_SET_SHAPE), word_t'(t_len[k]), word_t'(t_reps[k]), a);
    if (!a) note_error("shape instruction not accepted");
    issue_insn(make_insn(DMA_OPCODE, FN_SET_STRIDE), t_sstr[k], t_dstr[k], a);
    if (!a) note_error("stride instruction not accepted");
  endtask

  // Only bit 0 of rs1 picks the direction and the rest is noise
  task automatic launch(input logic dir);
    logic  a;
    word_t rs1;
    rs1    = $random(seed);
    rs1[0] = dir;
    issue_insn(make_insn(DMA_OPCODE, FN_START), rs1, '0, a);
    if (!a) note_error("start instruction not accepted");
  endtask

  // Word order matches the copy engine
  task automatic apply_model(input int k);
    addr_t sa;
    addr_t da;
    for (int r = 0; r < int'(t_reps[k]); r++) begin
      for (int w = 0; w < int'(t_len[k]); w++) begin
        sa = t_src[k] + addr_t'(r) * t_sstr[k] + addr_t'(w);
        da = t_dst[k] + addr_t'(r) * t_dstr[k] + addr_t'(w);
        if (!t_dir[k]) begin
          loc_ref[da] = ext_ref.exists(sa) ? ext_ref[sa] : fill_word(sa);
        end else begin
          ext_ref[da] = loc_ref.exists(sa) ? loc_ref[sa] : fill_word(sa);
        end
      end
    end
  endtask

  task automatic run_transfer(input int k);
    configure(k);
    launch(t_dir[k]);
    apply_model(k);
  endtask

  task automatic wait_done(input int target);
    while (done_cnt < target) @(posedge clk);
  endtask

  task automatic compare_mems();
    if (ext_mem.num() != ext_ref.num()) note_error("external memory written outside the model");
    if (loc_mem.num() != loc_ref.num()) note_error("local memory written outside the model");
    foreach (ext_ref[a]) begin
      if (!ext_mem.exists(a) || ext_mem[a] !== ext_ref[a]) begin
        note_error($sformatf("external word %0h is %0h, expected %0h", a, ext_mem[a], ext_ref[a]));
      end
    end
    foreach (loc_ref[a]) begin
      if (!loc_mem.exists(a) || loc_mem[a] !== loc_ref[a]) begin
        note_error($sformatf("local word %0h is %0h, expected %0h", a, loc_mem[a], loc_ref[a]));
      end
    end
  endtask

  task automatic finish_test(input string name, input int errs_at_start);
    if (errors == errs_at_start) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: failed with %0d errors", name, errors - errs_at_start);
    end
  endtask

  // Watchdog armed once the word count is known
  initial begin
    wait (timeout_cycles != 0);
    repeat (timeout_cycles) @(posedge clk);
    $display("timeout: transfers did not finish within %0d cycles", timeout_cycles);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    issue_valid = 1'b0;
    issue_instr = '0;
    issue_rs1 = '0;
    issue_rs2 = '0;
    ext_gnt = 1'b0;
    ext_rvalid = 1'b0;
    ext_rdata = '0;
    loc_gnt = 1'b0;
    loc_rvalid = 1'b0;
    loc_rdata = '0;
    gnt_mask = 32'd1;
    errors = 0;
    failed_tests = 0;
    total_words = 0;
    timeout_cycles = 0;
    start_cnt = 0;
    done_cnt = 0;
    err_cnt = 0;
    start_base = 0;
    done_base = 0;
    req_seen = 1'b0;
    busy_seen = 1'b0;
    busy_gap = 1'b0;
    watch_busy = 1'b0;
    // Random contents in both memories
    for (int a = 0; a < MEM_WORDS; a++) begin
      ext_mem[addr_t'(a)] = $random(seed);
      loc_mem[addr_t'(a)] = $random(seed);
    end
    ext_ref = ext_mem;
    loc_ref = loc_mem;
    // Shapes 2 to 4 run back to back and shape 5 follows foreign instructions
    for (int k = 0; k < NUM_XFERS; k++) begin
      t_src[k]  = addr_t'(pick(0, 127));
      t_dst[k]  = addr_t'(pick(0, 127));
      t_len[k]  = len_t'((k >= 2 && k <= 4) ? pick(4, 8) : pick(1, 8));
      t_reps[k] = len_t'((k == 0) ? 1 : (k == 1) ? pick(2, 4) : pick(1, 3));
      t_sstr[k] = addr_t'(pick(0, 16));
      t_dstr[k] = addr_t'(pick(0, 16));
      t_dir[k]  = (k == 0) ? 1'b0 : (k == 1) ? 1'b1 : (($random(seed) & 1) != 0);
      total_words += int'(t_len[k]) * int'(t_reps[k]);
    end
    timeout_cycles = 200 * total_words + 2000;

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Test 1 covers idle outputs and one row external to local
    errs_before = errors;
    if (!issue_ready || start || done || dma_error || busy || ext_req || loc_req) begin
      note_error("control outputs not idle after reset");
    end
    run_transfer(0);
    wait_done(1);
    compare_mems();
    finish_test("1 single row external to local", errs_before);

    // Test 2 copies strided rows local to external
    errs_before = errors;
    run_transfer(1);
    wait_done(2);
    compare_mems();
    finish_test("2 multi row local to external", errs_before);

    // Test 3 starts with zero length and then with zero rows
    errs_before = errors;
    repeat (2) @(posedge clk);
    start_base = start_cnt;
    err_base = err_cnt;
    req_seen = 1'b0;
    busy_seen = 1'b0;
    issue_insn(make_insn(DMA_OPCODE, FN_SET_SHAPE), '0, 32'd3, acc);
    launch(1'b0);
    repeat (4) @(posedge clk);
    issue_insn(make_insn(DMA_OPCODE, FN_SET_SHAPE), 32'd5, '0, acc);
    launch(1'b1);
    repeat (4) @(posedge clk);
    if (err_cnt != err_base + 2) begin
      note_error($sformatf("error pulses %0d, expected 2", err_cnt - err_base));
    end
    if (start_cnt != start_base) note_error("start pulsed for an empty shape");
    if (req_seen) note_error("memory request for an empty shape");
    if (busy_seen) note_error("busy raised for an empty shape");
    finish_test("3 rejected empty starts", errs_before);

    // Test 4 queues three transfers under slow grants
    errs_before = errors;
    gnt_mask = 32'd3;
    start_base = start_cnt;
    done_base = done_cnt;
    busy_gap = 1'b0;
    watch_busy = 1'b1;
    run_transfer(2);
    run_transfer(3);
    run_transfer(4);
    wait_done(done_base + 3);
    watch_busy = 1'b0;
    gnt_mask = 32'd1;
    if (start_cnt - start_base != 3) note_error("start did not pulse three times");
    if (start_cnt != done_cnt) note_error("start and done counts differ");
    if (busy_gap) note_error("busy dropped before the third done");
    compare_mems();
    finish_test("4 back to back transfers", errs_before);

    // Test 5 checks that foreign instructions leave the configuration alone
    errs_before = errors;
    done_base = done_cnt;
    configure(5);
    issue_insn(make_insn(7'b0110011, FN_SET_ADDR), $random(seed), $random(seed), acc);
    if (acc) note_error("wrong opcode accepted");
    issue_insn(make_insn(7'b0001011, FN_SET_SHAPE), '0, '0, acc);
    if (acc) note_error("custom-0 opcode accepted");
    issue_insn(make_insn(DMA_OPCODE, 3'd6), $random(seed), $random(seed), acc);
    if (acc) note_error("unused function code accepted");
    launch(t_dir[5]);
    apply_model(5);
    wait_done(done_base + 1);
    compare_mems();
    finish_test("5 foreign instructions ignored", errs_before);

    if (u_dut.u_assert.fail_count != 0) begin
      $display("%0d assertion failures during the run", u_dut.u_assert.fail_count);
      errors += int'(u_dut.u_assert.fail_count);
    end
    $display("tests run: 5, failed: %0d, errors: %0d", failed_tests, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/dma_ctrl_assert.sv
// DMA controller protocol assertions
`default_nettype none

module dma_ctrl_assert
  import dma_pkg::*;
(
  input logic  clk_i,
  input logic  rst_n_i,
  input logic  issue_valid_i,
  input logic  issue_ready_i,
  input logic  issue_accept_i,
  input logic  ext_req_i,
  input logic  ext_we_i,
  input addr_t ext_addr_i,
  input word_t ext_wdata_i,
  input logic  ext_gnt_i,
  input logic  loc_req_i,
  input logic  loc_we_i,
  input addr_t loc_addr_i,
  input word_t loc_wdata_i,
  input logic  loc_gnt_i,
  input logic  start_i,
  input logic  error_i,
  input logic  busy_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Failure count, read by the testbench at the end
  int unsigned fail_count = 0;

  // External request and its fields hold until granted
  ext_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ext_req_i && !ext_gnt_i |=> ext_req_i && $stable(ext_we_i) && $stable(ext_addr_i)
      && $stable(ext_wdata_i))
    else begin
      $error("external request changed before its grant");
      fail_count++;
    end

  // Same rule on the local side
  loc_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    loc_req_i && !loc_gnt_i |=> loc_req_i && $stable(loc_we_i) && $stable(loc_addr_i)
      && $stable(loc_wdata_i))
    else begin
      $error("local request changed before its grant");
      fail_count++;
    end

  // A start is either launched or rejected
  start_xor_error: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(start_i && error_i))
    else begin
      $error("start and error pulsed together");
      fail_count++;
    end

  // Accept only inside a handshake
  accept_in_handshake: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_accept_i |-> issue_valid_i && issue_ready_i)
    else begin
      $error("accept outside an issue handshake");
      fail_count++;
    end

  // Memory traffic only for an outstanding transfer
  req_while_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ext_req_i || loc_req_i) |-> busy_i)
    else begin
      $error("memory request while not busy");
      fail_count++;
    end

endmodule

bind dma_ctrl dma_ctrl_assert u_assert (
  .clk_i          ( clk_i          ),
  .rst_n_i        ( rst_n_i        ),
  .issue_valid_i  ( issue_valid_i  ),
  .issue_ready_i  ( issue_ready_o  ),
  .issue_accept_i ( issue_accept_o ),
  .ext_req_i      ( ext_req_o      ),
  .ext_we_i       ( ext_we_o       ),
  .ext_addr_i     ( ext_addr_o     ),
  .ext_wdata_i    ( ext_wdata_o    ),
  .ext_gnt_i      ( ext_gnt_i      ),
  .loc_req_i      ( loc_req_o      ),
  .loc_we_i       ( loc_we_o       ),
  .loc_addr_i     ( loc_addr_o     ),
  .loc_wdata_i    ( loc_wdata_o    ),
  .loc_gnt_i      ( loc_gnt_i      ),
  .start_i        ( start_o        ),
  .error_i        ( error_o        ),
  .busy_i         ( busy_o         )
);

`default_nettype wire

//--- source/dma_ctrl.sv
// DMA controller top level
`default_nettype none

module dma_ctrl
  import dma_pkg::*;
#(
  parameter int BURST_CREDITS = dma_pkg::BURST_CREDITS
)(
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Coprocessor issue port
  input  logic  issue_valid_i,
  input  word_t issue_instr_i,
  input  word_t issue_rs1_i,
  input  word_t issue_rs2_i,
  output logic  issue_ready_o,
  output logic  issue_accept_o,
  // External memory port
  output logic  ext_req_o,
  output logic  ext_we_o,
  output addr_t ext_addr_o,
  output word_t ext_wdata_o,
  input  logic  ext_gnt_i,
  input  logic  ext_rvalid_i,
  input  word_t ext_rdata_i,
  // Local memory port
  output logic  loc_req_o,
  output logic  loc_we_o,
  output addr_t loc_addr_o,
  output word_t loc_wdata_o,
  input  logic  loc_gnt_i,
  input  logic  loc_rvalid_i,
  input  word_t loc_rdata_i,
  // Status
  output logic  start_o,
  output logic  busy_o,
  output logic  done_o,
  output logic  error_o
);

  logic retire;

  dma_nd_req_if nd_if ();
  dma_burst_if  burst_if ();

  dma_insn_decoder i_decoder (
    .clk_i,
    .rst_n_i,
    .issue_valid_i,
    .issue_instr_i,
    .issue_rs1_i,
    .issue_rs2_i,
    .issue_ready_o,
    .issue_accept_o,
    .nd      ( nd_if   ),
    .start_o,
    .error_o
  );

  dma_nd_midend #(
    .BURST_CREDITS ( BURST_CREDITS )
  ) i_midend (
    .clk_i,
    .rst_n_i,
    .nd       ( nd_if    ),
    .burst    ( burst_if ),
    .retire_o ( retire   )
  );

  // Queue depth matches the mid-end credit count
  dma_backend #(
    .BURST_CREDITS ( BURST_CREDITS )
  ) i_backend (
    .clk_i,
    .rst_n_i,
    .burst ( burst_if ),
    .ext_req_o,
    .ext_we_o,
    .ext_addr_o,
    .ext_wdata_o,
    .ext_gnt_i,
    .ext_rvalid_i,
    .ext_rdata_i,
    .loc_req_o,
    .loc_we_o,
    .loc_addr_o,
    .loc_wdata_o,
    .loc_gnt_i,
    .loc_rvalid_i,
    .loc_rdata_i
  );

  // Issue on each start pulse, retire on each final burst
  dma_transfer_id i_transfer_id (
    .clk_i,
    .rst_n_i,
    .issue_i  ( start_o ),
    .retire_i ( retire  ),
    .busy_o
  );

  assign done_o = retire;

endmodule

`default_nettype wire

//--- source/dma_transfer_id.sv
// Transfer ID counters
`default_nettype none

module dma_transfer_id
  import dma_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic issue_i,
  input  logic retire_i,
  output logic busy_o
);

  // Both counters wrap, in-flight count stays far below the ID range
  id_t next_id_q;
  id_t done_id_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      next_id_q <= '0;
      done_id_q <= '0;
    end else begin
      if (issue_i) begin
        next_id_q <= next_id_q + id_t'(1);
      end
      if (retire_i) begin
        done_id_q <= done_id_q + id_t'(1);
      end
    end
  end

  // Outstanding work whenever the counters disagree
  assign busy_o = (next_id_q != done_id_q);

endmodule

`default_nettype wire

//--- source/dma_backend.sv
// Word copy back-end
`default_nettype none

module dma_backend
  import dma_pkg::*;
#(
  parameter int BURST_CREDITS = dma_pkg::BURST_CREDITS
)(
  input  logic        clk_i,
  input  logic        rst_n_i,
  dma_burst_if.slave  burst,
  output logic        ext_req_o,
  output logic        ext_we_o,
  output addr_t       ext_addr_o,
  output word_t       ext_wdata_o,
  input  logic        ext_gnt_i,
  input  logic        ext_rvalid_i,
  input  word_t       ext_rdata_i,
  output logic        loc_req_o,
  output logic        loc_we_o,
  output addr_t       loc_addr_o,
  output word_t       loc_wdata_o,
  input  logic        loc_gnt_i,
  input  logic        loc_rvalid_i,
  input  word_t       loc_rdata_i
);

  localparam int PTR_W = (BURST_CREDITS > 1) ? $clog2(BURST_CREDITS) : 1;
  localparam int CNT_W = $clog2(BURST_CREDITS + 1);

  // Burst queue storage
  addr_t            q_src  [BURST_CREDITS];
  addr_t            q_dst  [BURST_CREDITS];
  len_t             q_len  [BURST_CREDITS];
  logic             q_dir  [BURST_CREDITS];
  logic             q_last [BURST_CREDITS];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  be_state_e        state_q;
  // Burst in progress
  addr_t            cur_src_q;
  addr_t            cur_dst_q;
  len_t             words_left_q;
  logic             cur_dir_q;
  logic             cur_last_q;
  word_t            data_q;
  logic             pop;
  logic             rd_req;
  logic             wr_req;
  logic             rd_gnt;
  logic             wr_gnt;
  logic             rd_rvalid;
  word_t            rd_data;
  logic             last_word;

  assign pop       = (state_q == BE_IDLE) && (count_q != '0);
  assign rd_req    = (state_q == BE_RD_REQ);
  assign wr_req    = (state_q == BE_WR_REQ);
  assign last_word = (words_left_q == len_t'(1));

  // Direction picks the read side, dir 1 reads local
  assign rd_gnt    = cur_dir_q ? loc_gnt_i    : ext_gnt_i;
  assign rd_rvalid = cur_dir_q ? loc_rvalid_i : ext_rvalid_i;
  assign rd_data   = cur_dir_q ? loc_rdata_i  : ext_rdata_i;
  assign wr_gnt    = cur_dir_q ? ext_gnt_i    : loc_gnt_i;

  assign ext_req_o   = (rd_req && !cur_dir_q) || (wr_req && cur_dir_q);
  assign ext_we_o    = wr_req && cur_dir_q;
  assign ext_addr_o  = cur_dir_q ? cur_dst_q : cur_src_q;
  assign ext_wdata_o = data_q;
  assign loc_req_o   = (rd_req && cur_dir_q) || (wr_req && !cur_dir_q);
  assign loc_we_o    = wr_req && !cur_dir_q;
  assign loc_addr_o  = cur_dir_q ? cur_src_q : cur_dst_q;
  assign loc_wdata_o = data_q;

  // Credit goes back at the pop, completion at the final write grant
  assign burst.credit    = pop;
  assign burst.done      = wr_req && wr_gnt && last_word;
  assign burst.done_last = cur_last_q;

  // Queue pointers and FSM
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      state_q  <= BE_IDLE;
    end else begin
      // Credits guarantee room for every incoming burst
      if (burst.valid) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(BURST_CREDITS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(BURST_CREDITS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(burst.valid) - CNT_W'(pop);
      case (state_q)
        BE_IDLE:    if (pop) state_q <= BE_RD_REQ;
        BE_RD_REQ:  if (rd_gnt) state_q <= BE_RD_WAIT;
        // Read data comes one cycle after the grant
        BE_RD_WAIT: if (rd_rvalid) state_q <= BE_WR_REQ;
        BE_WR_REQ:  if (wr_gnt) state_q <= last_word ? BE_IDLE : BE_RD_REQ;
        default:    state_q <= BE_IDLE;
      endcase
    end
  end

  // Queue write side
  always_ff @(posedge clk_i) begin
    if (burst.valid) begin
      q_src[wr_ptr_q]  <= burst.src;
      q_dst[wr_ptr_q]  <= burst.dst;
      q_len[wr_ptr_q]  <= burst.len;
      q_dir[wr_ptr_q]  <= burst.dir;
      q_last[wr_ptr_q] <= burst.last;
    end
  end

  // Current burst and word buffer
  always_ff @(posedge clk_i) begin
    if (pop) begin
      cur_src_q    <= q_src[rd_ptr_q];
      cur_dst_q    <= q_dst[rd_ptr_q];
      words_left_q <= q_len[rd_ptr_q];
      cur_dir_q    <= q_dir[rd_ptr_q];
      cur_last_q   <= q_last[rd_ptr_q];
    end
    if (state_q == BE_RD_WAIT && rd_rvalid) begin
      data_q <= rd_data;
    end
    // Step both addresses one word per completed write
    if (wr_req && wr_gnt) begin
      cur_src_q    <= cur_src_q + addr_t'(1);
      cur_dst_q    <= cur_dst_q + addr_t'(1);
      words_left_q <= words_left_q - len_t'(1);
    end
  end

endmodule

`default_nettype wire

//--- source/dma_nd_midend.sv
// Row splitting mid-end
`default_nettype none

module dma_nd_midend
  import dma_pkg::*;
#(
  parameter int BURST_CREDITS = dma_pkg::BURST_CREDITS
)(
  input  logic         clk_i,
  input  logic         rst_n_i,
  dma_nd_req_if.slave  nd,
  dma_burst_if.master  burst,
  output logic         retire_o
);

  localparam int CNT_W = $clog2(BURST_CREDITS + 1);

  mid_state_e       state_q;
  logic [CNT_W-1:0] credits_q;
  len_t             rows_left_q;
  logic             retire_q;
  addr_t            src_row_q;
  addr_t            dst_row_q;
  addr_t            src_stride_q;
  addr_t            dst_stride_q;
  len_t             len_q;
  logic             dir_q;
  logic             take;
  logic             send;
  logic             last_row;

  // New requests only while idle
  assign nd.ready = (state_q == MID_IDLE);
  assign take     = nd.valid && nd.ready;
  // One burst per cycle as long as a credit is left
  assign send     = (state_q == MID_ISSUE) && (credits_q != '0);
  assign last_row = (rows_left_q == len_t'(1));

  assign burst.valid = send;
  assign burst.src   = src_row_q;
  assign burst.dst   = dst_row_q;
  assign burst.len   = len_q;
  assign burst.dir   = dir_q;
  assign burst.last  = last_row;

  // FSM, row counter, credits and retirement
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= MID_IDLE;
      rows_left_q <= '0;
      credits_q   <= CNT_W'(BURST_CREDITS);
      retire_q    <= 1'b0;
    end else begin
      // Spend one per burst, regain one per pop in the back-end
      credits_q <= credits_q - CNT_W'(send) + CNT_W'(burst.credit);
      retire_q  <= burst.done && burst.done_last;
      if (take) begin
        state_q     <= MID_ISSUE;
        rows_left_q <= nd.reps;
      end else if (send) begin
        rows_left_q <= rows_left_q - len_t'(1);
        // Free again right after the final row, the back-end may still be busy
        if (last_row) begin
          state_q <= MID_IDLE;
        end
      end
    end
  end

  // Running row addresses
  always_ff @(posedge clk_i) begin
    if (take) begin
      src_row_q    <= nd.src;
      dst_row_q    <= nd.dst;
      src_stride_q <= nd.src_stride;
      dst_stride_q <= nd.dst_stride;
      len_q        <= nd.len;
      dir_q        <= nd.dir;
    end else if (send) begin
      src_row_q <= src_row_q + src_stride_q;
      dst_row_q <= dst_row_q + dst_stride_q;
    end
  end

  assign retire_o = retire_q;

endmodule

`default_nettype wire

//--- source/dma_insn_decoder.sv
// Coprocessor instruction decoder
`default_nettype none

module dma_insn_decoder
  import dma_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         issue_valid_i,
  input  word_t        issue_instr_i,
  input  word_t        issue_rs1_i,
  input  word_t        issue_rs2_i,
  output logic         issue_ready_o,
  output logic         issue_accept_o,
  dma_nd_req_if.master nd,
  output logic         start_o,
  output logic         error_o
);

  logic [OPCODE_W-1:0] opcode;
  logic [FUNCT3_W-1:0] funct3;
  logic                fn_known;
  logic                accept;
  logic                shape_ok;
  addr_t               src_q;
  addr_t               dst_q;
  addr_t               src_stride_q;
  addr_t               dst_stride_q;
  len_t                len_q;
  len_t                reps_q;
  logic                dir_q;
  logic                req_valid_q;
  logic                start_q;
  logic                error_q;

  // Instruction fields
  assign opcode = issue_instr_i[OPCODE_LSB +: OPCODE_W];
  assign funct3 = issue_instr_i[FUNCT3_LSB +: FUNCT3_W];
  assign fn_known = funct3 inside {FN_SET_ADDR, FN_SET_SHAPE, FN_SET_STRIDE, FN_START};

  // Back-pressure while a request waits for the mid-end
  assign issue_ready_o = !req_valid_q;
  // Only our opcode with a known function code is accepted
  assign accept = issue_valid_i && issue_ready_o && (opcode == DMA_OPCODE) && fn_known;
  assign issue_accept_o = accept;

  // Empty rows or no rows at all are rejected
  assign shape_ok = (len_q != '0) && (reps_q != '0);

  // Shape registers and request control
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      len_q       <= '0;
      reps_q      <= '0;
      req_valid_q <= 1'b0;
      start_q     <= 1'b0;
      error_q     <= 1'b0;
    end else begin
      start_q <= 1'b0;
      error_q <= 1'b0;
      // Request leaves once the mid-end takes it
      if (nd.valid && nd.ready) begin
        req_valid_q <= 1'b0;
      end
      if (accept && funct3 == FN_SET_SHAPE) begin
        len_q  <= issue_rs1_i[LEN_W-1:0];
        reps_q <= issue_rs2_i[LEN_W-1:0];
      end
      if (accept && funct3 == FN_START) begin
        if (shape_ok) begin
          req_valid_q <= 1'b1;
          start_q     <= 1'b1;
        end else begin
          error_q <= 1'b1;
        end
      end
    end
  end

  // Address, stride and direction registers
  always_ff @(posedge clk_i) begin
    if (accept && funct3 == FN_SET_ADDR) begin
      src_q <= issue_rs1_i;
      dst_q <= issue_rs2_i;
    end
    if (accept && funct3 == FN_SET_STRIDE) begin
      src_stride_q <= issue_rs1_i;
      dst_stride_q <= issue_rs2_i;
    end
    // Direction is bit 0 of rs1
    if (accept && funct3 == FN_START && shape_ok) begin
      dir_q <= issue_rs1_i[0];
    end
  end

  // Registers stay put while the request is pending
  assign nd.valid      = req_valid_q;
  assign nd.src        = src_q;
  assign nd.dst        = dst_q;
  assign nd.len        = len_q;
  assign nd.reps       = reps_q;
  assign nd.src_stride = src_stride_q;
  assign nd.dst_stride = dst_stride_q;
  assign nd.dir        = dir_q;

  assign start_o = start_q;
  assign error_o = error_q;

endmodule

`default_nettype wire

//--- source/dma_burst_if.sv
// Credit-controlled burst link
`default_nettype none

interface dma_burst_if
  import dma_pkg::*;
();
  // Burst request, one cycle per burst
  logic  valid;
  addr_t src;
  addr_t dst;
  len_t  len;
  logic  dir;
  logic  last;
  // One credit back per burst popped from the queue
  logic  credit;
  // Burst completion
  logic  done;
  logic  done_last;

  modport master (
    output valid, src, dst, len, dir, last,
    input  credit, done, done_last
  );
  modport slave (
    input  valid, src, dst, len, dir, last,
    output credit, done, done_last
  );
endinterface

`default_nettype wire

//--- source/dma_nd_req_if.sv
// Two-dimensional transfer request
`default_nettype none

interface dma_nd_req_if
  import dma_pkg::*;
();
  logic  valid;
  logic  ready;
  addr_t src;
  addr_t dst;
  len_t  len;
  len_t  reps;
  addr_t src_stride;
  addr_t dst_stride;
  // 0 external to local, 1 local to external
  logic  dir;

  modport master (output valid, src, dst, len, reps, src_stride, dst_stride, dir, input ready);
  modport slave  (input valid, src, dst, len, reps, src_stride, dst_stride, dir, output ready);
endinterface

`default_nettype wire

//--- source/dma_pkg.sv
// DMA controller shared definitions
`default_nettype none

package dma_pkg;

  // Basic widths
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;
  localparam int LEN_W  = 12;
  localparam int ID_W   = 4;

  // Word address, counted in words
  typedef logic [ADDR_W-1:0] addr_t;
  // Data word and register operand
  typedef logic [WORD_W-1:0] word_t;
  // Row length in words and row count
  typedef logic [LEN_W-1:0]  len_t;
  // Transfer ID
  typedef logic [ID_W-1:0]   id_t;

  // Instruction field positions
  localparam int OPCODE_LSB = 0;
  localparam int OPCODE_W   = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int FUNCT3_W   = 3;

  // Custom-1 major opcode
  localparam logic [OPCODE_W-1:0] DMA_OPCODE = 7'b0101011;

  // Function codes
  localparam logic [FUNCT3_W-1:0] FN_SET_ADDR   = 3'd0;
  localparam logic [FUNCT3_W-1:0] FN_SET_SHAPE  = 3'd1;
  localparam logic [FUNCT3_W-1:0] FN_SET_STRIDE = 3'd2;
  localparam logic [FUNCT3_W-1:0] FN_START      = 3'd3;

  // Default back-end queue depth, also the mid-end credit count
  localparam int BURST_CREDITS = 4;

  // Mid-end FSM
  typedef enum logic [0:0] {
    MID_IDLE,
    MID_ISSUE
  } mid_state_e;

  // Back-end FSM, one word per pass through read and write
  typedef enum logic [1:0] {
    BE_IDLE,
    BE_RD_REQ,
    BE_RD_WAIT,
    BE_WR_REQ
  } be_state_e;

endpackage

`default_nettype wire
